//--- common/dma_writer_pkg.sv
////////////////////////////////////////////////////////////
// Writer geometry is fixed at compile time. Every channel
// drains a whole number of bursts and every burst a whole
// number of two-word beats
////////////////////////////////////////////////////////////
`default_nettype none

package dma_writer_pkg;

    // Input streams
    localparam int N_CHANNELS   = 4;
    localparam int SAMPLE_WIDTH = 32;
    localparam int DEST_WIDTH   = 16;
    localparam int USER_WIDTH   = 16;

    // A word is {user, dest, data}, two words make one beat
    localparam int WORD_WIDTH     = 64;
    localparam int BEAT_WIDTH     = 128;
    localparam int WORDS_PER_BEAT = 2;

    // Burst geometry
    localparam int BURST_LEN       = 4;
    localparam int BURST_BYTES     = 64;
    localparam int CHANNEL_SAMPLES = 16;
    localparam int ADDR_WIDTH      = 32;
    localparam int BURSTS_PER_RUN  =
        N_CHANNELS * CHANNEL_SAMPLES / (WORDS_PER_BEAT * BURST_LEN);

    // Counter widths, one spare bit so the final count is representable
    localparam int BURST_IDX_WIDTH  = $clog2(BURSTS_PER_RUN) + 1;
    localparam int BEAT_CNT_WIDTH   = $clog2(BURST_LEN) + 1;
    localparam int SAMPLE_CNT_WIDTH = $clog2(CHANNEL_SAMPLES) + 1;

    typedef logic [1:0] sel_t;

    typedef enum logic [2:0] {
        idle,
        start_burst,
        send_beat,
        wait_response,
        next_channel
    } writer_state_t;

endpackage

`default_nettype wire

//--- common/axi_write_pkg.sv
////////////////////////////////////////////////////////////
// Only the AXI write fields the writer drives are defined.
// Beats are always 16 bytes wide with every strobe set
////////////////////////////////////////////////////////////
`default_nettype none

package axi_write_pkg;

    localparam int AXI_LEN_WIDTH   = 8;
    localparam int AXI_SIZE_WIDTH  = 3;
    localparam int AXI_BURST_WIDTH = 2;
    localparam int WSTRB_WIDTH     = 16;

    localparam logic [AXI_SIZE_WIDTH-1:0]  AXI_SIZE_16B   = 3'b100;
    localparam logic [AXI_BURST_WIDTH-1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [WSTRB_WIDTH-1:0]     WSTRB_ALL      = '1;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_t;

endpackage

`default_nettype wire

//--- hw/channel_select.sv
////////////////////////////////////////////////////////////
// Purely combinational. The selector must only change
// while no sample handshake is pending on the old channel
////////////////////////////////////////////////////////////
`default_nettype none

module channel_select
    import dma_writer_pkg::*;
(
    input  wire [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] in_data,
    input  wire [N_CHANNELS-1:0][DEST_WIDTH-1:0]   in_dest,
    input  wire [N_CHANNELS-1:0][USER_WIDTH-1:0]   in_user,
    input  wire [N_CHANNELS-1:0]                   in_valid,
    output logic [N_CHANNELS-1:0]                  in_ready,
    input  wire sel_t                              selector,
    output logic [SAMPLE_WIDTH-1:0]                sample_data,
    output logic [DEST_WIDTH-1:0]                  sample_dest,
    output logic [USER_WIDTH-1:0]                  sample_user,
    output logic                                   sample_valid,
    input  wire                                    sample_ready
);

    // Forward path
    assign sample_data  = in_data[selector];
    assign sample_dest  = in_dest[selector];
    assign sample_user  = in_user[selector];
    assign sample_valid = in_valid[selector];

    // Ready goes back to the selected channel only
    always_comb begin
        in_ready           = '0;
        in_ready[selector] = sample_ready;
    end

endmodule

`default_nettype wire

//--- hw/word_packer.sv
////////////////////////////////////////////////////////////
// Holds at most one beat. Samples are taken only while the
// consumer asks for a beat and the output register is empty
////////////////////////////////////////////////////////////
`default_nettype none

module word_packer
    import dma_writer_pkg::*;
(
    input  wire                     clock,
    input  wire                     reset,
    input  wire [SAMPLE_WIDTH-1:0]  sample_data,
    input  wire [DEST_WIDTH-1:0]    sample_dest,
    input  wire [USER_WIDTH-1:0]    sample_user,
    input  wire                     sample_valid,
    output logic                    sample_ready,
    output logic [BEAT_WIDTH-1:0]   beat_data,
    output logic                    beat_valid,
    input  wire                     beat_ready
);

    logic [WORD_WIDTH-1:0]             word;
    logic [$clog2(WORDS_PER_BEAT)-1:0] word_count;
    logic                              word_take;

    assign word         = {sample_user, sample_dest, sample_data};
    assign sample_ready = beat_ready && !beat_valid;
    assign word_take    = sample_valid && sample_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            word_count <= '0;
            beat_valid <= 1'b0;
        end else begin
            if (beat_valid && beat_ready) begin
                beat_valid <= 1'b0;
            end
            if (word_take) begin
                if (word_count == WORDS_PER_BEAT - 1) begin
                    word_count <= '0;
                    beat_valid <= 1'b1;
                end else begin
                    word_count <= word_count + 1'b1;
                end
            end
        end
    end

    // Low half fills first
    always_ff @(posedge clock) begin
        if (word_take) begin
            beat_data[word_count*WORD_WIDTH +: WORD_WIDTH] <= word;
        end
    end

    a_beat_stable: assert property (@(posedge clock) disable iff (!reset)
        (beat_valid && !beat_ready) |=> $stable(beat_data));

endmodule

`default_nettype wire

//--- hw/burst_writer/burst_counters.sv
////////////////////////////////////////////////////////////
// The burst index runs on across channels, so addresses
// grow without gaps from the base of the run
////////////////////////////////////////////////////////////
`default_nettype none

module burst_counters
    import dma_writer_pkg::*;
(
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    clear_counts,
    input  wire                    load_base,
    input  wire [ADDR_WIDTH-1:0]   base_addr,
    input  wire                    beat_sent,
    input  wire                    burst_sent,
    input  wire                    advance_channel,
    output logic [ADDR_WIDTH-1:0]  burst_addr,
    output logic                   last_beat,
    output logic                   channel_complete,
    output logic                   last_channel,
    output sel_t                   selector
);

    logic [ADDR_WIDTH-1:0]       target_base;
    logic [BURST_IDX_WIDTH-1:0]  burst_index;
    logic [BEAT_CNT_WIDTH-1:0]   beat_count;
    logic [SAMPLE_CNT_WIDTH-1:0] sample_count;

    assign burst_addr = target_base
        + ADDR_WIDTH'(burst_index) * ADDR_WIDTH'(BURST_BYTES);
    assign last_beat        = beat_count == BEAT_CNT_WIDTH'(BURST_LEN - 1);
    assign channel_complete = sample_count == SAMPLE_CNT_WIDTH'(CHANNEL_SAMPLES);
    assign last_channel     = selector == sel_t'(N_CHANNELS - 1);

    always_ff @(posedge clock) begin
        if (load_base) begin
            target_base <= base_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset || clear_counts) begin
            burst_index  <= '0;
            beat_count   <= '0;
            sample_count <= '0;
            selector     <= '0;
        end else begin
            if (beat_sent) begin
                beat_count <= last_beat ? '0 : beat_count + 1'b1;
            end
            if (burst_sent) begin
                burst_index <= burst_index + 1'b1;
            end
            // Moving on starts the next channel's sample tally
            if (advance_channel) begin
                selector     <= selector + 1'b1;
                sample_count <= '0;
            end else if (beat_sent) begin
                sample_count <= sample_count + SAMPLE_CNT_WIDTH'(WORDS_PER_BEAT);
            end
        end
    end

    a_beat_count_range: assert property (@(posedge clock) disable iff (!reset)
        beat_count <= BEAT_CNT_WIDTH'(BURST_LEN - 1));

endmodule

`default_nettype wire

//--- hw/burst_writer/burst_writer_fsm.sv
////////////////////////////////////////////////////////////
// One burst in flight at a time, one W beat outstanding at
// a time. Write responses other than OKAY are not handled
////////////////////////////////////////////////////////////
`default_nettype none

module burst_writer_fsm
    import dma_writer_pkg::*, axi_write_pkg::*;
(
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         buffer_full,
    input  wire                         disable_dma,
    input  wire [BEAT_WIDTH-1:0]        beat_data,
    input  wire                         beat_valid,
    output logic                        beat_ready,
    output logic [ADDR_WIDTH-1:0]       aw_addr,
    output logic [AXI_LEN_WIDTH-1:0]    aw_len,
    output logic [AXI_SIZE_WIDTH-1:0]   aw_size,
    output logic [AXI_BURST_WIDTH-1:0]  aw_burst,
    output logic                        aw_valid,
    input  wire                         aw_ready,
    output logic [BEAT_WIDTH-1:0]       w_data,
    output logic [WSTRB_WIDTH-1:0]      w_strb,
    output logic                        w_last,
    output logic                        w_valid,
    input  wire                         w_ready,
    input  wire                         b_valid,
    input  wire axi_resp_t              b_resp,
    output logic                        b_ready,
    input  wire [ADDR_WIDTH-1:0]        burst_addr,
    input  wire                         last_beat,
    input  wire                         channel_complete,
    input  wire                         last_channel,
    output logic                        load_base,
    output logic                        clear_counts,
    output logic                        beat_sent,
    output logic                        burst_sent,
    output logic                        advance_channel,
    output logic                        dma_done
);

    writer_state_t state;
    logic          start_run;
    logic          beat_take;
    logic          w_take;

    assign start_run = (state == idle) && buffer_full && !disable_dma;
    assign beat_take = beat_valid && beat_ready;
    assign w_take    = w_valid && w_ready;

    ////////////////////////////////////////////////////////////
    // Counter strobes
    ////////////////////////////////////////////////////////////
    assign load_base       = start_run;
    assign clear_counts    = start_run;
    assign beat_sent       = w_take;
    assign burst_sent      = (state == wait_response) && b_valid;
    assign advance_channel = (state == next_channel) && !last_channel && !disable_dma;

    // Fixed burst shape
    assign aw_len   = AXI_LEN_WIDTH'(BURST_LEN - 1);
    assign aw_size  = AXI_SIZE_16B;
    assign aw_burst = AXI_BURST_INCR;
    assign w_strb   = WSTRB_ALL;
    assign b_ready  = 1'b1;

    ////////////////////////////////////////////////////////////
    // Writer sequence
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= idle;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            w_last     <= 1'b0;
            beat_ready <= 1'b0;
            dma_done   <= 1'b0;
        end else begin
            dma_done <= 1'b0;
            unique case (state)
                idle: begin
                    if (start_run) begin
                        state <= start_burst;
                    end
                end
                start_burst: begin
                    // Address goes out one clock after entry
                    if (!aw_valid) begin
                        aw_valid <= 1'b1;
                    end else if (aw_ready) begin
                        aw_valid   <= 1'b0;
                        beat_ready <= 1'b1;
                        state      <= send_beat;
                    end
                end
                send_beat: begin
                    if (beat_take) begin
                        beat_ready <= 1'b0;
                        w_valid    <= 1'b1;
                        w_last     <= last_beat;
                    end
                    if (w_take) begin
                        w_valid <= 1'b0;
                        if (w_last) begin
                            state <= wait_response;
                        end else begin
                            beat_ready <= 1'b1;
                        end
                    end
                end
                wait_response: begin
                    if (b_valid) begin
                        state <= channel_complete ? next_channel : start_burst;
                    end
                end
                next_channel: begin
                    // A disable here ends the run at the channel boundary
                    if (last_channel || disable_dma) begin
                        dma_done <= 1'b1;
                        state    <= idle;
                    end else begin
                        state <= start_burst;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if ((state == start_burst) && !aw_valid) begin
            aw_addr <= burst_addr;
        end
        if (beat_take) begin
            w_data <= beat_data;
        end
    end

    a_w_last_on_last_beat: assert property (@(posedge clock) disable iff (!reset)
        w_take |-> (w_last == last_beat));

    a_aw_only_in_start: assert property (@(posedge clock) disable iff (!reset)
        aw_valid |-> (state == start_burst));

    a_resp_okay: assert property (@(posedge clock) disable iff (!reset)
        burst_sent |-> (b_resp == okay));

endmodule

`default_nettype wire

//--- hw/dma_mc_writer.sv
////////////////////////////////////////////////////////////
// AXI write side only, fixed 128-bit data. A run starts
// when buffer_full is seen in idle with disable_dma low
////////////////////////////////////////////////////////////
`default_nettype none

module dma_mc_writer
    import dma_writer_pkg::*, axi_write_pkg::*;
(
    input  wire                                    clock,
    input  wire                                    reset,
    input  wire                                    disable_dma,
    input  wire                                    buffer_full,
    input  wire [ADDR_WIDTH-1:0]                   dma_base_addr,
    input  wire [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] in_data,
    input  wire [N_CHANNELS-1:0][DEST_WIDTH-1:0]   in_dest,
    input  wire [N_CHANNELS-1:0][USER_WIDTH-1:0]   in_user,
    input  wire [N_CHANNELS-1:0]                   in_valid,
    output logic [N_CHANNELS-1:0]                  in_ready,
    output logic [ADDR_WIDTH-1:0]                  aw_addr,
    output logic [AXI_LEN_WIDTH-1:0]               aw_len,
    output logic [AXI_SIZE_WIDTH-1:0]              aw_size,
    output logic [AXI_BURST_WIDTH-1:0]             aw_burst,
    output logic                                   aw_valid,
    input  wire                                    aw_ready,
    output logic [BEAT_WIDTH-1:0]                  w_data,
    output logic [WSTRB_WIDTH-1:0]                 w_strb,
    output logic                                   w_last,
    output logic                                   w_valid,
    input  wire                                    w_ready,
    input  wire                                    b_valid,
    input  wire axi_resp_t                         b_resp,
    output logic                                   b_ready,
    output logic                                   dma_done
);

    sel_t                    selector;
    logic [SAMPLE_WIDTH-1:0] sample_data;
    logic [DEST_WIDTH-1:0]   sample_dest;
    logic [USER_WIDTH-1:0]   sample_user;
    logic                    sample_valid;
    logic                    sample_ready;
    logic [BEAT_WIDTH-1:0]   beat_data;
    logic                    beat_valid;
    logic                    beat_ready;
    logic [ADDR_WIDTH-1:0]   burst_addr;
    logic                    last_beat;
    logic                    channel_complete;
    logic                    last_channel;
    logic                    load_base;
    logic                    clear_counts;
    logic                    beat_sent;
    logic                    burst_sent;
    logic                    advance_channel;

    channel_select u_select (
        .in_data, .in_dest, .in_user, .in_valid, .in_ready, .selector,
        .sample_data, .sample_dest, .sample_user, .sample_valid, .sample_ready
    );

    word_packer u_packer (
        .clock, .reset, .sample_data, .sample_dest, .sample_user,
        .sample_valid, .sample_ready, .beat_data, .beat_valid, .beat_ready
    );

    burst_counters u_counters (
        .clock, .reset, .clear_counts, .load_base, .base_addr(dma_base_addr),
        .beat_sent, .burst_sent, .advance_channel, .burst_addr, .last_beat,
        .channel_complete, .last_channel, .selector
    );

    burst_writer_fsm u_fsm (
        .clock, .reset, .buffer_full, .disable_dma, .beat_data, .beat_valid,
        .beat_ready, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_last, .w_valid, .w_ready, .b_valid, .b_resp, .b_ready,
        .burst_addr, .last_beat, .channel_complete, .last_channel, .load_base,
        .clear_counts, .beat_sent, .burst_sent, .advance_channel, .dma_done
    );

endmodule

`default_nettype wire

//--- sim/dma_mc_writer_tb.sv
////////////////////////////////////////////////////////////
// Sample indices carry over from run to run, so the tests
// only hold when they run in the order given in main
////////////////////////////////////////////////////////////
`default_nettype none

module dma_mc_writer_tb
    import dma_writer_pkg::*, axi_write_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD    = 40;
    localparam int RUN_BEATS       = N_CHANNELS * CHANNEL_SAMPLES / WORDS_PER_BEAT;
    localparam int CHANNEL_BEATS   = CHANNEL_SAMPLES / WORDS_PER_BEAT;
    localparam int TOTAL_BEATS     = 3 * RUN_BEATS + CHANNEL_BEATS;
    // The idle test adds a fixed window of 200 clocks
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_BEATS + 200;

    logic                                    clock = 1'b0;
    logic                                    reset = 1'b0;
    logic                                    disable_dma = 1'b0;
    logic                                    buffer_full = 1'b0;
    logic [ADDR_WIDTH-1:0]                   dma_base_addr = '0;
    logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] in_data = '0;
    logic [N_CHANNELS-1:0][DEST_WIDTH-1:0]   in_dest = '0;
    logic [N_CHANNELS-1:0][USER_WIDTH-1:0]   in_user = '0;
    logic [N_CHANNELS-1:0]                   in_valid = '0;
    logic                                    aw_ready = 1'b0;
    logic                                    w_ready = 1'b0;
    logic                                    b_valid = 1'b0;
    axi_resp_t                               b_resp = okay;

    logic [N_CHANNELS-1:0]       in_ready;
    logic [ADDR_WIDTH-1:0]       aw_addr;
    logic [AXI_LEN_WIDTH-1:0]    aw_len;
    logic [AXI_SIZE_WIDTH-1:0]   aw_size;
    logic [AXI_BURST_WIDTH-1:0]  aw_burst;
    logic [BEAT_WIDTH-1:0]       w_data;
    logic [WSTRB_WIDTH-1:0]      w_strb;
    logic                        aw_valid, w_last, w_valid, b_ready, dma_done;

    logic                  stall = 1'b0;
    logic [31:0]           rng = 32'h1b0d_6dd1;
    int                    src_index [N_CHANNELS] = '{default: 0};
    int                    model_index [N_CHANNELS] = '{default: 0};
    logic [ADDR_WIDTH-1:0] aw_seen [$];
    logic [BEAT_WIDTH-1:0] w_seen [$];
    int                    beat_in_burst = 0;
    int                    b_count = 0;
    int                    done_count = 0;
    int                    done_bursts = 0;
    int                    protocol_errors = 0;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    fail_mark, aw_mark, w_mark, b_mark, done_mark;
    string                 current_test = "";

    dma_mc_writer uut (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word layout is {user, dest, data}, user being the inverted index
    function automatic logic [WORD_WIDTH-1:0] sample_word(input int ch, input int idx);
        return {~USER_WIDTH'(idx), DEST_WIDTH'(ch), SAMPLE_WIDTH'(ch * 256 + idx)};
    endfunction

    ////////////////////////////////////////////////////////////
    // Sources, ready gating and memory-side responder
    ////////////////////////////////////////////////////////////
    always @(posedge clock) begin : bus_model
        logic [31:0] r;
        int          next_index;
        int          bad;
        r = xorshift(rng);
        bad = 0;
        rng      <= r;
        aw_ready <= !stall || r[0];
        w_ready  <= !stall || r[1];
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            next_index = src_index[ch] + int'(in_valid[ch] && in_ready[ch]);
            src_index[ch] <= next_index;
            {in_user[ch], in_dest[ch], in_data[ch]} <= sample_word(ch, next_index);
            // A raised valid waits for its handshake
            in_valid[ch] <= (in_valid[ch] && !in_ready[ch]) || !stall || r[2 + ch];
        end
        if (aw_valid && aw_ready) begin
            aw_seen.push_back(aw_addr);
            // AXI encodes the beat count less one
            if (int'(aw_len) + 1 != BURST_LEN) begin
                $display("[ERROR] %s: aw_len expected %0d, actual %0d",
                         current_test, BURST_LEN - 1, aw_len);
                bad++;
            end
            // Bytes per beat are two to the power of aw_size
            if ((1 << aw_size) !== BEAT_WIDTH / 8) begin
                $display("[ERROR] %s: aw_size expected %0d, actual %0d",
                         current_test, $clog2(BEAT_WIDTH / 8), aw_size);
                bad++;
            end
            if (aw_burst !== 2'b01) begin
                $display("[ERROR] %s: aw_burst expected %b, actual %b",
                         current_test, 2'b01, aw_burst);
                bad++;
            end
        end
        if (w_valid && w_ready) begin
            w_seen.push_back(w_data);
            if (w_last !== (beat_in_burst == BURST_LEN - 1)) begin
                $display("[ERROR] %s: w_last on beat %0d expected %b, actual %b",
                         current_test, beat_in_burst,
                         beat_in_burst == BURST_LEN - 1, w_last);
                bad++;
            end
            if (w_strb !== '1) begin
                $display("[ERROR] %s: w_strb expected %h, actual %h",
                         current_test, {WSTRB_WIDTH{1'b1}}, w_strb);
                bad++;
            end
            beat_in_burst <= (beat_in_burst == BURST_LEN - 1) ? 0 : beat_in_burst + 1;
        end
        protocol_errors <= protocol_errors + bad;
        // One OKAY response per burst, sent after its last beat
        if (b_valid && b_ready) begin
            b_valid <= 1'b0;
            b_count <= b_count + 1;
        end
        if (w_valid && w_ready && w_last) begin
            b_valid <= 1'b1;
        end
        if (dma_done) begin
            done_count  <= done_count + 1;
            done_bursts <= b_count;
        end
    end

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] expected,
                              input logic [ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input logic [BEAT_WIDTH-1:0] expected,
                              input logic [BEAT_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_done(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s dma_done pulses: expected %0d, actual %0d",
                     name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic open_test(input string name);
        current_test = name;
        fail_mark    = errors + protocol_errors;
        aw_mark      = aw_seen.size();
        w_mark       = w_seen.size();
        b_mark       = b_count;
        done_mark    = done_count;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors + protocol_errors == fail_mark) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    // The writer sees buffer_full for exactly one clock
    task automatic begin_run(input logic [ADDR_WIDTH-1:0] base);
        @(posedge clock);
        dma_base_addr <= base;
        buffer_full   <= 1'b1;
        @(posedge clock);
        buffer_full   <= 1'b0;
    endtask

    task automatic wait_for_done(input string name, input int max_cycles);
        int n;
        n = 0;
        while (!dma_done && n < max_cycles) begin
            @(posedge clock);
            n++;
        end
        if (!dma_done) begin
            $display("%s: dma_done did not arrive within %0d clocks", name, max_cycles);
            errors++;
        end
        // Late or repeated strobes get a chance to show up
        repeat (20) @(posedge clock);
    endtask

    task automatic check_run(input string name, input logic [ADDR_WIDTH-1:0] base,
                             input int channels);
        int                    bursts;
        int                    ch;
        int                    first;
        logic [BEAT_WIDTH-1:0] expected;
        bursts = channels * CHANNEL_SAMPLES / (WORDS_PER_BEAT * BURST_LEN);
        check_count({name, " bursts"}, bursts, aw_seen.size() - aw_mark);
        check_count({name, " beats"}, bursts * BURST_LEN, w_seen.size() - w_mark);
        check_count({name, " responses before done"}, bursts, done_bursts - b_mark);
        check_done(name, 1, done_count - done_mark);
        for (int k = 0; k < bursts && aw_mark + k < aw_seen.size(); k++) begin
            check_addr(name, base + ADDR_WIDTH'(k * BURST_BYTES), aw_seen[aw_mark + k]);
        end
        // Beat k holds samples 2k and 2k+1 of the run, low word first
        for (int k = 0; k < bursts * BURST_LEN && w_mark + k < w_seen.size(); k++) begin
            ch       = k * WORDS_PER_BEAT / CHANNEL_SAMPLES;
            first    = model_index[ch] + (k * WORDS_PER_BEAT) % CHANNEL_SAMPLES;
            expected = {sample_word(ch, first + 1), sample_word(ch, first)};
            check_beat(name, expected, w_seen[w_mark + k]);
        end
        for (int c = 0; c < channels; c++) begin
            model_index[c] += CHANNEL_SAMPLES;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic reset_values();
        open_test("reset_values");
        check_flag("reset_values aw_valid", 1'b0, aw_valid);
        check_flag("reset_values w_valid", 1'b0, w_valid);
        check_flag("reset_values dma_done", 1'b0, dma_done);
        check_flag("reset_values b_ready", 1'b1, b_ready);
        close_test("reset_values");
    endtask

    task automatic drain_all(input string name, input logic [ADDR_WIDTH-1:0] base);
        open_test(name);
        begin_run(base);
        wait_for_done(name, 40 * RUN_BEATS);
        check_run(name, base, N_CHANNELS);
        close_test(name);
    endtask

    task automatic idle_while_disabled();
        int aw_cycles;
        aw_cycles = 0;
        open_test("idle_while_disabled");
        @(posedge clock);
        disable_dma <= 1'b1;
        buffer_full <= 1'b1;
        repeat (200) begin
            @(posedge clock);
            aw_cycles += int'(aw_valid);
        end
        buffer_full <= 1'b0;
        @(posedge clock);
        disable_dma <= 1'b0;
        check_count("idle_while_disabled aw_valid clocks", 0, aw_cycles);
        check_done("idle_while_disabled", 0, done_count - done_mark);
        close_test("idle_while_disabled");
    endtask

    task automatic disable_in_channel0();
        int n;
        n = 0;
        open_test("disable_in_channel0");
        begin_run(32'h0000_8000);
        while (!(aw_valid && aw_ready) && n < 200) begin
            @(posedge clock);
            n++;
        end
        disable_dma <= 1'b1;
        wait_for_done("disable_in_channel0", 40 * CHANNEL_BEATS);
        disable_dma <= 1'b0;
        check_run("disable_in_channel0", 32'h0000_8000, 1);
        close_test("disable_in_channel0");
    endtask

    initial begin : main
        repeat (4) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        reset_values();
        drain_all("full_run", 32'h1000_0000);
        stall <= 1'b1;
        drain_all("stalled_run", 32'h2000_0400);
        stall <= 1'b0;
        idle_while_disabled();
        disable_in_channel0();
        drain_all("rerun_new_base", 32'h3000_1000);
        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, errors + protocol_errors);
        if (errors + protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d clocks with tests still running",
                 WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dma_mc_writer.f
common/dma_writer_pkg.sv
common/axi_write_pkg.sv
hw/channel_select.sv
hw/word_packer.sv
hw/burst_writer/burst_counters.sv
hw/burst_writer/burst_writer_fsm.sv
hw/dma_mc_writer.sv
sim/dma_mc_writer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f dma_mc_writer.f --top-module dma_mc_writer_tb -o dma_mc_writer_tb

./obj_dir/dma_mc_writer_tb | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
